// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_tcdm_arb_sys
FILELIST  := tcdm_arb_sys.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_tcdm_arb_sys.sv ====
// testbench for the tcdm arbitration subsystem, seeded random traffic on both ports
`timescale 1ns/1ns
`include "tcdm_params.svh"

module tb_tcdm_arb_sys;

  localparam int AW      = `TCDM_ADDR_W;
  localparam int DW      = `TCDM_DATA_W;
  localparam int BW      = `TCDM_BE_W;
  localparam int IDX_W   = $clog2(`TCDM_BANK_WORDS);
  localparam int OFS_W   = $clog2(`TCDM_BE_W);
  localparam int MAX_TXN = 64;
  localparam int N_TESTS = 5;

  logic          clk;
  logic          rst_n;
  logic          p0_req;
  logic [AW-1:0] p0_addr;
  logic          p0_we;
  logic [BW-1:0] p0_be;
  logic [DW-1:0] p0_wdata;
  logic          p0_gnt;
  logic          p0_rvalid;
  logic [DW-1:0] p0_rdata;
  logic          p1_req;
  logic [AW-1:0] p1_addr;
  logic          p1_we;
  logic [BW-1:0] p1_be;
  logic [DW-1:0] p1_wdata;
  logic          p1_gnt;
  logic          p1_rvalid;
  logic [DW-1:0] p1_rdata;
  int            err_cnt;
  int            pending;
  int            tests_run;
  int            cycles;
  logic [31:0]   lcg_state;

  // per-port transaction lists, filled before each test starts
  logic          t_we   [2][MAX_TXN];
  logic [AW-1:0] t_addr [2][MAX_TXN];
  logic [BW-1:0] t_be   [2][MAX_TXN];
  logic [DW-1:0] t_data [2][MAX_TXN];
  logic          t_gap  [2][MAX_TXN];  // one idle cycle before this request
  int            t_cnt  [2];

  tcdm_arb_sys tcdm_arb_sys_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .p0_req_i    (p0_req),
    .p0_addr_i   (p0_addr),
    .p0_we_i     (p0_we),
    .p0_be_i     (p0_be),
    .p0_wdata_i  (p0_wdata),
    .p0_gnt_o    (p0_gnt),
    .p0_rvalid_o (p0_rvalid),
    .p0_rdata_o  (p0_rdata),
    .p1_req_i    (p1_req),
    .p1_addr_i   (p1_addr),
    .p1_we_i     (p1_we),
    .p1_be_i     (p1_be),
    .p1_wdata_i  (p1_wdata),
    .p1_gnt_o    (p1_gnt),
    .p1_rvalid_o (p1_rvalid),
    .p1_rdata_o  (p1_rdata)
  );

  tcdm_checker tcdm_checker_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .p0_req_i    (p0_req),
    .p0_addr_i   (p0_addr),
    .p0_we_i     (p0_we),
    .p0_be_i     (p0_be),
    .p0_wdata_i  (p0_wdata),
    .p0_gnt_i    (p0_gnt),
    .p0_rvalid_i (p0_rvalid),
    .p0_rdata_i  (p0_rdata),
    .p1_req_i    (p1_req),
    .p1_addr_i   (p1_addr),
    .p1_we_i     (p1_we),
    .p1_be_i     (p1_be),
    .p1_wdata_i  (p1_wdata),
    .p1_gnt_i    (p1_gnt),
    .p1_rvalid_i (p1_rvalid),
    .p1_rdata_i  (p1_rdata),
    .err_cnt_o   (err_cnt),
    .pending_o   (pending)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // transactions per test times the longest grant wait in that test, four times over
  function automatic int timeout_limit();
    int txns     [N_TESTS];
    int wait_max [N_TESTS];
    int sum;
    txns     = '{32, 32, 32, 24, 48};
    wait_max = '{3, 3, 20, 3, 26};
    sum      = 0;
    for (int i = 0; i < N_TESTS; i++) begin
      sum += txns[i] * wait_max[i];
    end
    return 4 * sum;
  endfunction

  function automatic void drive_port(int port, logic req, logic we, logic [AW-1:0] addr,
                                     logic [BW-1:0] be, logic [DW-1:0] data);
    if (port == 1) begin
      p1_req   = req;
      p1_we    = we;
      p1_addr  = addr;
      p1_be    = be;
      p1_wdata = data;
    end else begin
      p0_req   = req;
      p0_we    = we;
      p0_addr  = addr;
      p0_be    = be;
      p0_wdata = data;
    end
  endfunction

  function automatic logic gnt_of(int port);
    return (port == 1) ? p1_gnt : p0_gnt;
  endfunction

  function automatic void clear_plan();
    t_cnt[0] = 0;
    t_cnt[1] = 0;
  endfunction

  // bits outside the word index are random, the bank must ignore them
  function automatic void add_txn(int port, logic we, logic [IDX_W-1:0] idx, logic [BW-1:0] be,
                                  logic [DW-1:0] data, logic gap);
    logic [31:0] r;
    int          n;
    n = t_cnt[port];
    r = lcg_next();
    t_addr[port][n] = {r[31:IDX_W+OFS_W], idx, r[OFS_W-1:0]};
    t_we[port][n]   = we;
    t_be[port][n]   = be;
    t_data[port][n] = data;
    t_gap[port][n]  = gap;
    t_cnt[port]     = n + 1;
  endfunction

  function automatic void plan_single(int port);
    logic [IDX_W-1:0] idx [16];
    logic [31:0]      r;
    clear_plan();
    for (int i = 0; i < 16; i++) begin
      r      = lcg_next();
      idx[i] = r[IDX_W-1:0];
      add_txn(port, 1'b1, idx[i], '1, lcg_next(), 1'b0);
    end
    for (int i = 0; i < 16; i++) begin
      add_txn(port, 1'b0, idx[i], '1, lcg_next(), 1'b0);
    end
  endfunction

  function automatic void plan_contention();
    logic [IDX_W-1:0] idx [2][8];
    logic [31:0]      r;
    clear_plan();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 8; i++) begin
        r         = lcg_next();
        idx[p][i] = r[IDX_W-1:0];
        add_txn(p, 1'b1, idx[p][i], '1, lcg_next(), 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
        add_txn(p, 1'b0, idx[p][i], '1, lcg_next(), 1'b0);
      end
    end
  endfunction

  // full word first, then a partial overwrite, then the read back
  function automatic void plan_byte_enables();
    logic [IDX_W-1:0] idx [8];
    logic [31:0]      r;
    clear_plan();
    for (int i = 0; i < 8; i++) begin
      r      = lcg_next();
      idx[i] = r[IDX_W-1:0];
      add_txn(0, 1'b1, idx[i], '1, lcg_next(), 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      r = lcg_next();
      add_txn(0, 1'b1, idx[i], r[BW-1:0], lcg_next(), 1'b0);
    end
    for (int i = 0; i < 8; i++) begin
      add_txn(0, 1'b0, idx[i], '1, lcg_next(), 1'b0);
    end
  endfunction

  function automatic void plan_mixed();
    logic [31:0] r;
    clear_plan();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < 24; i++) begin
        r = lcg_next();
        add_txn(p, r[0], r[8 +: IDX_W], r[4 +: BW], lcg_next(), (p == 1) && r[16]);
      end
    end
  endfunction

  task automatic run_port(int port);
    for (int i = 0; i < t_cnt[port]; i++) begin
      if (t_gap[port][i]) begin
        @(negedge clk);
        drive_port(port, 1'b0, 1'b0, '0, '0, '0);
      end
      @(negedge clk);
      drive_port(port, 1'b1, t_we[port][i], t_addr[port][i], t_be[port][i], t_data[port][i]);
      do @(posedge clk); while (!gnt_of(port));  // request held until granted
    end
    @(negedge clk);
    drive_port(port, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic run_test(string name);
    int errors_before;
    errors_before = err_cnt;
    fork
      run_port(0);
      run_port(1);
    join
    do @(posedge clk); while (pending != 0);
    repeat (2) @(posedge clk);
    tests_run++;
    $display("test %0d, %s: %0d errors", tests_run, name, err_cnt - errors_before);
  endtask

  initial begin
    lcg_state = 32'hc5e30ece;
    tests_run = 0;
    rst_n     = 1'b0;
    drive_port(0, 1'b0, 1'b0, '0, '0, '0);
    drive_port(1, 1'b0, 1'b0, '0, '0, '0);
    clear_plan();
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    plan_single(0);
    run_test("port 0 alone");
    plan_single(1);
    run_test("port 1 alone");
    plan_contention();
    run_test("contention");
    plan_byte_enables();
    run_test("byte enables");
    plan_mixed();
    run_test("mixed traffic");

    $display("%0d tests done, %0d errors in total", tests_run, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_limit()) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, a request or response never completed", cycles);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== bench/tcdm_arb_properties.sv ====
// tcdm mux properties: route fifo occupancy against grants and responses, grant exclusivity
`timescale 1ns/1ns
`include "tcdm_params.svh"

module tcdm_arb_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic push_i,
  input logic pop_i,
  input logic full_i,
  input logic empty_i,
  input logic gnt0_i,
  input logic gnt1_i,
  input logic rsp_valid_i
);

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_i))
    else $error("route fifo pushed while full");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) !(pop_i && empty_i))
    else $error("route fifo popped while empty");

  // only one requester may own the bank in a cycle
  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni) !(gnt0_i && gnt1_i))
    else $error("both ports granted in the same cycle");

  // a bank response belongs to the transfer recorded one latency earlier
  a_rsp_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i |-> !empty_i && $past(push_i, `TCDM_RSP_LATENCY))
    else $error("bank response with no outstanding request recorded");

endmodule

bind tcdm_prio_mux tcdm_arb_properties i_arb_properties (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .push_i      (fifo_push),
  .pop_i       (fifo_pop),
  .full_i      (route_full),
  .empty_i     (route_empty),
  .gnt0_i      (slv0_i.rsp.gnt),
  .gnt1_i      (slv1_i.rsp.gnt),
  .rsp_valid_i (mst_o.rsp.valid)
);

// ==== bench/tcdm_checker.sv ====
// tcdm checker: predicts grants, models the bank and compares every response at the top ports
`timescale 1ns/1ns
`include "tcdm_params.svh"

module tcdm_checker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    p0_req_i,
  input  logic [`TCDM_ADDR_W-1:0] p0_addr_i,
  input  logic                    p0_we_i,
  input  logic [`TCDM_BE_W-1:0]   p0_be_i,
  input  logic [`TCDM_DATA_W-1:0] p0_wdata_i,
  input  logic                    p0_gnt_i,
  input  logic                    p0_rvalid_i,
  input  logic [`TCDM_DATA_W-1:0] p0_rdata_i,
  input  logic                    p1_req_i,
  input  logic [`TCDM_ADDR_W-1:0] p1_addr_i,
  input  logic                    p1_we_i,
  input  logic [`TCDM_BE_W-1:0]   p1_be_i,
  input  logic [`TCDM_DATA_W-1:0] p1_wdata_i,
  input  logic                    p1_gnt_i,
  input  logic                    p1_rvalid_i,
  input  logic [`TCDM_DATA_W-1:0] p1_rdata_i,
  output int                      err_cnt_o,
  output int                      pending_o
);

  localparam int DW    = `TCDM_DATA_W;
  localparam int BW    = `TCDM_BE_W;
  localparam int LAT   = `TCDM_RSP_LATENCY;
  localparam int IDX_W = $clog2(`TCDM_BANK_WORDS);
  localparam int OFS_W = $clog2(`TCDM_BE_W);

  // one expected response: the cycle it is due, which bytes are known, and their value
  typedef struct packed {
    logic [31:0]   due;
    logic [DW-1:0] mask;
    logic [DW-1:0] data;
  } exp_rsp_t;

  logic [DW-1:0] model_mem  [`TCDM_BANK_WORDS];
  bit   [BW-1:0] byte_known [`TCDM_BANK_WORDS];  // bytes never written stay unchecked
  exp_rsp_t      q0 [$];
  exp_rsp_t      q1 [$];
  int unsigned   cycle;
  int            errors;

  function automatic bit head_due(int port);
    if (port == 1) return q1.size() > 0 && q1[0].due == cycle;
    return q0.size() > 0 && q0[0].due == cycle;
  endfunction

  function automatic exp_rsp_t pop_exp(int port);
    if (port == 1) return q1.pop_front();
    return q0.pop_front();
  endfunction

  function automatic void check_gnt(int port, logic gnt, logic expected);
    if (gnt !== expected) begin
      $display("FAILED p%0d_gnt_o: expected %h, got %h", port, expected, gnt);
      errors++;
    end
  endfunction

  function automatic void check_rsp(int port, logic rvalid, logic [DW-1:0] rdata);
    exp_rsp_t e;
    if (head_due(port)) begin
      e = pop_exp(port);
      if (!rvalid) begin
        $display("port %0d: response due in cycle %0d never arrived", port, cycle);
        errors++;
      end else if ((rdata & e.mask) !== e.data) begin
        $display("FAILED p%0d_rdata_o: expected %h, got %h", port, e.data, rdata & e.mask);
        errors++;
      end
    end else if (rvalid) begin
      $display("port %0d: rvalid in cycle %0d with no response due on this port", port, cycle);
      errors++;
    end else if (rdata !== '0) begin
      $display("FAILED p%0d_rdata_o: expected %h, got %h", port, {DW{1'b0}}, rdata);
      errors++;
    end
  endfunction

  // the access lands in the model on the granting edge, just like in the bank
  function automatic void record_grant(int port, logic [31:0] addr, logic we,
                                       logic [BW-1:0] be, logic [DW-1:0] wdata);
    logic [IDX_W-1:0] idx;
    exp_rsp_t         e;
    idx   = addr[OFS_W +: IDX_W];
    e.due = cycle + LAT;
    if (we) begin
      for (int b = 0; b < BW; b++) begin
        if (be[b]) begin
          model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
          byte_known[idx][b]       = 1'b1;
        end
      end
      e.mask = '1;
      e.data = '0;  // writes answer with zero data
    end else begin
      for (int b = 0; b < BW; b++) begin
        e.mask[8*b +: 8] = {8{byte_known[idx][b]}};
      end
      e.data = model_mem[idx] & e.mask;
    end
    if (port == 1) q1.push_back(e);
    else q0.push_back(e);
  endfunction

  always @(posedge clk_i) begin
    if (rst_ni) begin
      check_gnt(0, p0_gnt_i, p0_req_i && !p1_req_i);
      check_gnt(1, p1_gnt_i, p1_req_i);
      check_rsp(0, p0_rvalid_i, p0_rdata_i);
      check_rsp(1, p1_rvalid_i, p1_rdata_i);
      if (p1_req_i) begin
        record_grant(1, p1_addr_i, p1_we_i, p1_be_i, p1_wdata_i);
      end else if (p0_req_i) begin
        record_grant(0, p0_addr_i, p0_we_i, p0_be_i, p0_wdata_i);
      end
    end
    cycle++;
    err_cnt_o <= errors;
    pending_o <= q0.size() + q1.size();
  end

endmodule

// ==== hw/tcdm_arb_sys.sv ====
// tcdm arbitration subsystem: two requesters share one sram bank through a priority mux
`timescale 1ns/1ns
`include "tcdm_params.svh"

module tcdm_arb_sys (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // port 0, lower priority
  input  logic                    p0_req_i,
  input  logic [`TCDM_ADDR_W-1:0] p0_addr_i,
  input  logic                    p0_we_i,
  input  logic [`TCDM_BE_W-1:0]   p0_be_i,
  input  logic [`TCDM_DATA_W-1:0] p0_wdata_i,
  output logic                    p0_gnt_o,
  output logic                    p0_rvalid_o,
  output logic [`TCDM_DATA_W-1:0] p0_rdata_o,

  // port 1 wins every conflict
  input  logic                    p1_req_i,
  input  logic [`TCDM_ADDR_W-1:0] p1_addr_i,
  input  logic                    p1_we_i,
  input  logic [`TCDM_BE_W-1:0]   p1_be_i,
  input  logic [`TCDM_DATA_W-1:0] p1_wdata_i,
  output logic                    p1_gnt_o,
  output logic                    p1_rvalid_o,
  output logic [`TCDM_DATA_W-1:0] p1_rdata_o
);

  tcdm_if p0_bus ();
  tcdm_if p1_bus ();
  tcdm_if mem_bus ();

  assign p0_bus.req.req  = p0_req_i;
  assign p0_bus.req.addr = p0_addr_i;
  assign p0_bus.req.we   = p0_we_i;
  assign p0_bus.req.be   = p0_be_i;
  assign p0_bus.req.data = p0_wdata_i;

  assign p0_gnt_o    = p0_bus.rsp.gnt;
  assign p0_rvalid_o = p0_bus.rsp.valid;
  assign p0_rdata_o  = p0_bus.rsp.data;

  assign p1_bus.req.req  = p1_req_i;
  assign p1_bus.req.addr = p1_addr_i;
  assign p1_bus.req.we   = p1_we_i;
  assign p1_bus.req.be   = p1_be_i;
  assign p1_bus.req.data = p1_wdata_i;

  assign p1_gnt_o    = p1_bus.rsp.gnt;
  assign p1_rvalid_o = p1_bus.rsp.valid;
  assign p1_rdata_o  = p1_bus.rsp.data;

  tcdm_prio_mux i_prio_mux (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .slv0_i (p0_bus),
    .slv1_i (p1_bus),
    .mst_o  (mem_bus)
  );

  tcdm_sram_bank i_sram_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .bus_i  (mem_bus)
  );

endmodule

// ==== hw/tcdm_if.sv ====
// tcdm bus: one request record towards memory and one response record back
`timescale 1ns/1ns

interface tcdm_if import tcdm_pkg::*; ();

  tcdm_req_t req;
  tcdm_rsp_t rsp;

  // requester side
  modport master (
    output req,
    input  rsp
  );

  // memory side, grants and answers
  modport slave (
    input  req,
    output rsp
  );

endinterface

// ==== hw/tcdm_params.svh ====
// tcdm subsystem parameters: bus widths, bank geometry, response latency and route depth
`ifndef TCDM_PARAMS_SVH
`define TCDM_PARAMS_SVH

// bus widths, addr is a byte address
`define TCDM_ADDR_W 32
`define TCDM_DATA_W 32
`define TCDM_BE_W   4

// single bank of 32-bit words
`define TCDM_BANK_WORDS 256

// cycles from the granting edge to the response strobe
`define TCDM_RSP_LATENCY 2

// must cover every request that can be outstanding, so keep it >= TCDM_RSP_LATENCY
`define TCDM_ROUTE_DEPTH 4

`endif

// ==== hw/tcdm_pkg.sv ====
// tcdm shared types: request and response records and the one-hot port select
`include "tcdm_params.svh"

package tcdm_pkg;

  // request side, held stable by the requester until gnt
  typedef struct packed {
    logic                    req;
    logic [`TCDM_ADDR_W-1:0] addr;
    logic                    we;    // 1 = write, 0 = read
    logic [`TCDM_BE_W-1:0]   be;
    logic [`TCDM_DATA_W-1:0] data;
  } tcdm_req_t;

  // response side, valid is a single-cycle strobe with no back-pressure
  typedef struct packed {
    logic                    gnt;
    logic                    valid;
    logic [`TCDM_DATA_W-1:0] data;  // zero whenever valid is low
  } tcdm_rsp_t;

  // one-hot, bit 0 is port 0 and bit 1 is port 1
  typedef logic [1:0] port_sel_t;

  localparam port_sel_t SEL_NONE = 2'b00;
  localparam port_sel_t PORT0    = 2'b01;
  localparam port_sel_t PORT1    = 2'b10;

endpackage

// ==== hw/tcdm_prio_mux.sv ====
// fixed-priority 2-to-1 tcdm multiplexer, port 1 wins, responses routed back in grant order
`timescale 1ns/1ns

module tcdm_prio_mux import tcdm_pkg::*; (
  input logic        clk_i,
  input logic        rst_ni,
  tcdm_if.slave      slv0_i,
  tcdm_if.slave      slv1_i,
  tcdm_if.master     mst_o
);

  port_sel_t win_sel;     // requester that owns the bank this cycle
  port_sel_t route_sel;   // owner of the oldest outstanding request
  logic      route_empty;
  logic      route_full;
  logic      fifo_push;
  logic      fifo_pop;
  logic      rsp_valid;

  // port 1 takes the bank whenever it asks, port 0 only gets the leftovers
  always_comb begin
    if (slv1_i.req.req) begin
      win_sel = PORT1;
    end else if (slv0_i.req.req) begin
      win_sel = PORT0;
    end else begin
      win_sel = SEL_NONE;
    end
  end

  // the winner's record goes out whole, its req bit is low only when nobody asks
  assign mst_o.req = win_sel[1] ? slv1_i.req : slv0_i.req;

  assign fifo_push = mst_o.req.req & mst_o.rsp.gnt;  // one entry per accepted transfer
  assign fifo_pop  = mst_o.rsp.valid;
  assign rsp_valid = mst_o.rsp.valid & ~route_empty;

  tcdm_route_fifo i_route_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (fifo_push),
    .sel_i   (win_sel),
    .pop_i   (fifo_pop),
    .sel_o   (route_sel),
    .empty_o (route_empty),
    .full_o  (route_full)
  );

  // grant goes to the winner only, the response to whoever the head entry names
  always_comb begin
    slv0_i.rsp     = '0;
    slv1_i.rsp     = '0;
    slv0_i.rsp.gnt = win_sel[0] & mst_o.rsp.gnt;
    slv1_i.rsp.gnt = win_sel[1] & mst_o.rsp.gnt;

    if (rsp_valid) begin
      if (route_sel == PORT1) begin
        slv1_i.rsp.valid = 1'b1;
        slv1_i.rsp.data  = mst_o.rsp.data;
      end else if (route_sel == PORT0) begin
        slv0_i.rsp.valid = 1'b1;
        slv0_i.rsp.data  = mst_o.rsp.data;
      end
    end
  end

endmodule

// ==== hw/tcdm_route_fifo.sv ====
// route fifo: remembers in grant order which port owns each outstanding tcdm request
`timescale 1ns/1ns
`include "tcdm_params.svh"

module tcdm_route_fifo import tcdm_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      push_i,
  input  port_sel_t sel_i,
  input  logic      pop_i,
  output port_sel_t sel_o,
  output logic      empty_o,
  output logic      full_o
);

  localparam int unsigned DEPTH = `TCDM_ROUTE_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  port_sel_t        mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));

  // a pop frees the head slot in the same cycle, so push into a full fifo is fine then
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  assign sel_o = mem_q[rd_ptr_q];  // oldest entry, meaningless while empty

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // idle, or push and pop cancel out
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= sel_i;
    end
  end

endmodule

// ==== hw/tcdm_sram_bank.sv ====
// single-ported sram bank with byte enables, grants at once and answers after a fixed latency
`timescale 1ns/1ns
`include "tcdm_params.svh"

module tcdm_sram_bank (
  input logic   clk_i,
  input logic   rst_ni,
  tcdm_if.slave bus_i
);

  localparam int unsigned WORDS = `TCDM_BANK_WORDS;
  localparam int unsigned LAT   = `TCDM_RSP_LATENCY;
  localparam int unsigned BE_W  = `TCDM_BE_W;
  localparam int unsigned DW    = `TCDM_DATA_W;
  localparam int unsigned IDX_W = $clog2(WORDS);
  localparam int unsigned OFS_W = $clog2(BE_W);  // byte offset bits below the word index

  logic [DW-1:0]    mem_q [WORDS];
  logic [IDX_W-1:0] idx;
  logic             access;
  logic             vld_q  [LAT];
  logic [DW-1:0]    data_q [LAT];

  assign idx    = bus_i.req.addr[OFS_W +: IDX_W];
  assign access = bus_i.req.req;  // never stalls, every request is taken

  // write the enabled bytes on the granting edge
  always_ff @(posedge clk_i) begin
    if (access && bus_i.req.we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bus_i.req.be[b]) begin
          mem_q[idx][8*b +: 8] <= bus_i.req.data[8*b +: 8];
        end
      end
    end
  end

  // valid travels down the pipeline, one slot per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < LAT; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else begin
      vld_q[0] <= access;
      for (int i = 1; i < LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // read word is captured on the grant, writes answer with zero
  always_ff @(posedge clk_i) begin
    data_q[0] <= (access && !bus_i.req.we) ? mem_q[idx] : '0;
    for (int i = 1; i < LAT; i++) begin
      data_q[i] <= data_q[i-1];
    end
  end

  assign bus_i.rsp.gnt   = bus_i.req.req;
  assign bus_i.rsp.valid = vld_q[LAT-1];
  assign bus_i.rsp.data  = vld_q[LAT-1] ? data_q[LAT-1] : '0;

endmodule

// ==== tcdm_arb_sys.f ====
+incdir+hw
hw/tcdm_pkg.sv
hw/tcdm_if.sv
hw/tcdm_route_fifo.sv
hw/tcdm_prio_mux.sv
hw/tcdm_sram_bank.sv
hw/tcdm_arb_sys.sv
bench/tcdm_checker.sv
bench/tcdm_arb_properties.sv
bench/tb_tcdm_arb_sys.sv
